// File: Bender.yml
package:
  name: erx_core

sources:
  - erx_link_pkg.sv
  - erx_cfg_pkg.sv
  - erx_deser.sv
  - erx_decode.sv
  - erx_queue.sv
  - erx_dispatch.sv
  - erx_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_erx_core.sv

// File: erx_cfg_pkg.sv
//##############################
// receive side configuration
// queue sizing, pushback level and the
// deserializer frame phase
//##############################
package erx_cfg_pkg;

   localparam int QDEPTH     = 8;  // entries per class
   localparam int QAW        = 3;  // log2 of QDEPTH
   localparam int WAIT_LEVEL = 4;  // leaves room for packets in flight

   // position of the word pointer within a frame
   typedef enum logic [1:0] {
      PH_IDLE  = 2'd0,   // no frame
      PH_HEAD  = 2'd1,   // first packet of frame
      PH_BURST = 2'd2    // frame open past a full sample
   } deser_phase_t;

endpackage

// File: erx_core.f
+incdir+.
erx_link_pkg.sv
erx_cfg_pkg.sv
erx_deser.sv
erx_decode.sv
erx_queue.sv
erx_dispatch.sv
erx_core.sv
tb_erx_core.sv

// File: erx_core.sv
`timescale 1ns/10ps
//##############################
// receive link top level
// sampled link words in, packets out to the local
// consumer, rd/wr pushback back to the transmitter
//##############################
module erx_core (
   input  logic                              rx_lclk,
   input  logic                              erx_io_nreset,
   input  logic                              link_frame,
   input  logic [erx_link_pkg::LW-1:0]       link_word,
   input  logic                              rx_wait,
   output logic                              link_wr_wait,
   output logic                              link_rd_wait,
   output logic                              rx_access,
   output logic                              rx_burst,
   output logic [erx_link_pkg::PW-1:0]       rx_packet
);

   logic                          sample_valid;
   logic [erx_link_pkg::SW-1:0]   sample;
   erx_cfg_pkg::deser_phase_t     phase;
   logic                          pkt_valid;
   logic [erx_link_pkg::PW-1:0]   pkt;
   logic                          pkt_burst;

   erx_deser u_deser (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .link_frame    (link_frame),
      .link_word     (link_word),
      .sample_valid  (sample_valid),
      .sample        (sample),
      .phase         (phase)
   );

   erx_decode u_decode (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .sample_valid  (sample_valid),
      .sample        (sample),
      .phase         (phase),
      .pkt_valid     (pkt_valid),
      .pkt           (pkt),
      .pkt_burst     (pkt_burst)
   );

   erx_dispatch u_dispatch (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .pkt_valid     (pkt_valid),
      .pkt           (pkt),
      .pkt_burst     (pkt_burst),
      .rx_wait       (rx_wait),
      .link_wr_wait  (link_wr_wait),
      .link_rd_wait  (link_rd_wait),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_packet     (rx_packet)
   );

endmodule

// File: erx_decode.sv
`timescale 1ns/10ps
//##############################
// sample to packet reorder
// maps a completed 112 bit sample onto the 104 bit
// packet fields one cycle after sample_valid and
// flags every packet of a frame after the first
//##############################
module erx_decode (
   input  logic                              rx_lclk,
   input  logic                              erx_io_nreset,
   input  logic                              sample_valid,
   input  logic [erx_link_pkg::SW-1:0]       sample,
   input  erx_cfg_pkg::deser_phase_t         phase,
   output logic                              pkt_valid,
   output logic [erx_link_pkg::PW-1:0]       pkt,
   output logic                              pkt_burst
);

   erx_link_pkg::datamode_t             dm;        // transfer size
   logic [3:0]                          cm;
   logic [erx_link_pkg::AW-1:0]         dst;
   logic [erx_link_pkg::AW-1:0]         data;
   logic [erx_link_pkg::AW-1:0]         src;
   logic                                burst_detect;

   //##############################
   // field extraction
   //##############################
   assign dm   = erx_link_pkg::datamode_t'(sample[43:42]);
   assign cm   = sample[15:12];

   // byte swapped on the wire
   assign dst  = {sample[11:8],
                  sample[23:16],
                  sample[31:24],
                  sample[39:32],
                  sample[47:44]};
   assign data = {sample[55:48],
                  sample[63:56],
                  sample[71:64],
                  sample[79:72]};
   assign src  = {sample[87:80],
                  sample[95:88],
                  sample[103:96],
                  sample[111:104]};

   //##############################
   // burst detect
   //##############################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         burst_detect <= 1'b0;
      else if (sample_valid && (phase == erx_cfg_pkg::PH_BURST))
         burst_detect <= 1'b1;               // frame stays high
      else if (phase == erx_cfg_pkg::PH_IDLE)
         burst_detect <= 1'b0;               // frame end
   end

   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         pkt_valid <= 1'b0;
      else
         pkt_valid <= sample_valid;
   end

   // packet register, burst reads the old flag
   always_ff @(posedge rx_lclk)
   begin
      if (sample_valid)
      begin
         pkt_burst                                          <= burst_detect;
         pkt[erx_link_pkg::ACC_BIT]                         <= sample[40];
         pkt[erx_link_pkg::WR_BIT]                          <= sample[41];
         pkt[erx_link_pkg::DM_LSB +: 2]                     <= dm;
         pkt[erx_link_pkg::CM_LSB +: 4]                     <= cm;
         pkt[erx_link_pkg::DST_LSB +: erx_link_pkg::AW]     <= dst;
         pkt[erx_link_pkg::DATA_LSB +: erx_link_pkg::AW]    <= data;
         pkt[erx_link_pkg::SRC_LSB +: erx_link_pkg::AW]     <= src;
      end
   end

endmodule

// File: erx_deser.sv
`timescale 1ns/10ps
//##############################
// link word deserializer
// registers the sampled link words and frame flag,
// walks a one-hot slot pointer and builds 112 bit
// samples, pulses sample_valid when one is complete
//##############################
module erx_deser (
   input  logic                              rx_lclk,
   input  logic                              erx_io_nreset,
   input  logic                              link_frame,
   input  logic [erx_link_pkg::LW-1:0]       link_word,
   output logic                              sample_valid,
   output logic [erx_link_pkg::SW-1:0]       sample,
   output erx_cfg_pkg::deser_phase_t         phase
);

   logic                                rx_frame;    // registered frame
   logic [erx_link_pkg::LW-1:0]         rx_word;     // registered word
   logic [erx_link_pkg::NSLOT-1:0]      rx_pointer;  // one-hot slot
   erx_cfg_pkg::deser_phase_t           ph_q;

   //##############################
   // input registers
   //##############################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         rx_frame <= 1'b0;
      else
         rx_frame <= link_frame;
   end

   always_ff @(posedge rx_lclk)
      rx_word <= link_word;

   //##############################
   // slot pointer
   //##############################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
         rx_pointer <= '0;
      else if (!rx_frame)
         rx_pointer <= erx_link_pkg::PTR_FIRST;   // wait for new frame
      else if (rx_pointer[erx_link_pkg::NSLOT-1])
         rx_pointer <= erx_link_pkg::PTR_BURST;   // anticipate burst
      else
         rx_pointer <= {rx_pointer[erx_link_pkg::NSLOT-2:0], 1'b0};
   end

   // each slot loads its own slice
   always_ff @(posedge rx_lclk)
   begin
      for (int i = 0; i < erx_link_pkg::NSLOT; i++)
      begin
         if (rx_pointer[i])
            sample[i*erx_link_pkg::LW +: erx_link_pkg::LW] <= rx_word;
      end
   end

   //##############################
   // sample done and frame phase
   //##############################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         sample_valid <= 1'b0;
         ph_q         <= erx_cfg_pkg::PH_IDLE;
      end
      else
      begin
         // last slot written this edge
         sample_valid <= rx_pointer[erx_link_pkg::NSLOT-1] & rx_frame;
         if (!rx_frame)
            ph_q <= erx_cfg_pkg::PH_IDLE;
         else if (rx_pointer[erx_link_pkg::NSLOT-1])
            ph_q <= erx_cfg_pkg::PH_BURST;        // sample done, frame on
         else if (ph_q == erx_cfg_pkg::PH_IDLE)
            ph_q <= erx_cfg_pkg::PH_HEAD;
      end
   end

   // frame drop shows up at once
   assign phase = rx_frame ? ph_q : erx_cfg_pkg::PH_IDLE;

endmodule

// File: erx_dispatch.sv
`timescale 1ns/10ps
//##############################
// class steering and output stage
// writes and reads go to their own queue, each queue
// drives its link pushback pin, a round-robin pick
// feeds the registered consumer interface
//##############################
module erx_dispatch (
   input  logic                              rx_lclk,
   input  logic                              erx_io_nreset,
   input  logic                              pkt_valid,
   input  logic [erx_link_pkg::PW-1:0]       pkt,
   input  logic                              pkt_burst,
   input  logic                              rx_wait,
   output logic                              link_wr_wait,
   output logic                              link_rd_wait,
   output logic                              rx_access,
   output logic                              rx_burst,
   output logic [erx_link_pkg::PW-1:0]       rx_packet
);

   logic                          wr_push;
   logic                          rd_push;
   logic [erx_link_pkg::PW-1:0]   wr_head;
   logic [erx_link_pkg::PW-1:0]   rd_head;
   logic                          wr_head_burst;
   logic                          rd_head_burst;
   logic [erx_cfg_pkg::QAW:0]     wr_count;
   logic [erx_cfg_pkg::QAW:0]     rd_count;
   logic                          wr_empty;
   logic                          rd_empty;
   logic                          out_free;   // stage empty or taken
   logic                          pick_wr;
   logic                          pick_rd;
   logic                          rr_rd;      // read queue has priority

   //##############################
   // steering and pushback
   //##############################
   assign wr_push = pkt_valid &  pkt[erx_link_pkg::WR_BIT];
   assign rd_push = pkt_valid & ~pkt[erx_link_pkg::WR_BIT];

   assign link_wr_wait = (wr_count >= erx_cfg_pkg::WAIT_LEVEL);
   assign link_rd_wait = (rd_count >= erx_cfg_pkg::WAIT_LEVEL);

   erx_queue q_wr (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .push          (wr_push),
      .push_pkt      (pkt),
      .push_burst    (pkt_burst),
      .pop           (pick_wr),
      .head_pkt      (wr_head),
      .head_burst    (wr_head_burst),
      .count         (wr_count),
      .empty         (wr_empty)
   );

   erx_queue q_rd (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .push          (rd_push),
      .push_pkt      (pkt),
      .push_burst    (pkt_burst),
      .pop           (pick_rd),
      .head_pkt      (rd_head),
      .head_burst    (rd_head_burst),
      .count         (rd_count),
      .empty         (rd_empty)
   );

   //##############################
   // round-robin pick
   //##############################
   assign out_free = !rx_access | !rx_wait;
   assign pick_wr  = out_free & !wr_empty & (!rr_rd | rd_empty);
   assign pick_rd  = out_free & !rd_empty & !pick_wr;

   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         rx_access <= 1'b0;
         rr_rd     <= 1'b0;
      end
      else
      begin
         if (pick_wr | pick_rd)
            rx_access <= 1'b1;
         else if (out_free)
            rx_access <= 1'b0;   // taken, nothing new
         if (pick_wr)
            rr_rd <= 1'b1;       // reads next
         else if (pick_rd)
            rr_rd <= 1'b0;
      end
   end

   // output register holds while rx_wait
   always_ff @(posedge rx_lclk)
   begin
      if (pick_wr)
      begin
         rx_packet <= wr_head;
         rx_burst  <= wr_head_burst;
      end
      else if (pick_rd)
      begin
         rx_packet <= rd_head;
         rx_burst  <= rd_head_burst;
      end
   end

endmodule

// File: erx_link_pkg.sv
//##############################
// link packet layout for the receive path
// word, sample and packet widths, field offsets
// and the datamode encoding, shared by rtl and testbench
//##############################
package erx_link_pkg;

   //##############################
   // widths
   //##############################
   localparam int LW    = 16;       // link word, two bytes per lclk
   localparam int NSLOT = 7;        // words per full sample
   localparam int SW    = NSLOT*LW; // 112 bit sample
   localparam int PW    = 104;      // emesh style packet
   localparam int AW    = 32;       // addr and data fields

   //##############################
   // packet field positions
   //##############################
   localparam int ACC_BIT  = 0;
   localparam int WR_BIT   = 1;
   localparam int DM_LSB   = 2;     // 2 bits
   localparam int CM_LSB   = 4;     // 4 bits
   localparam int DST_LSB  = 8;
   localparam int DATA_LSB = 40;
   localparam int SRC_LSB  = 72;

   // burst restarts at the data slot
   localparam int BURST_SLOT = 3;
   localparam logic [NSLOT-1:0] PTR_FIRST = 1;
   localparam logic [NSLOT-1:0] PTR_BURST = PTR_FIRST << BURST_SLOT;

   // transfer size
   typedef enum logic [1:0] {
      DM_BYTE   = 2'd0,
      DM_HALF   = 2'd1,
      DM_WORD   = 2'd2,
      DM_DOUBLE = 2'd3
   } datamode_t;

endpackage

// File: erx_queue.sv
`timescale 1ns/10ps
//##############################
// packet FIFO for one class
// circular buffer with fill count, combinational head,
// push and pop allowed in the same cycle
//##############################
module erx_queue (
   input  logic                              rx_lclk,
   input  logic                              erx_io_nreset,
   input  logic                              push,
   input  logic [erx_link_pkg::PW-1:0]       push_pkt,
   input  logic                              push_burst,
   input  logic                              pop,
   output logic [erx_link_pkg::PW-1:0]       head_pkt,
   output logic                              head_burst,
   output logic [erx_cfg_pkg::QAW:0]         count,
   output logic                              empty
);

   logic [erx_link_pkg::PW-1:0]   mem_pkt   [erx_cfg_pkg::QDEPTH];
   logic                          mem_burst [erx_cfg_pkg::QDEPTH];
   logic [erx_cfg_pkg::QAW-1:0]   wr_ptr;
   logic [erx_cfg_pkg::QAW-1:0]   rd_ptr;
   logic                          full;
   logic                          do_push;
   logic                          do_pop;

   assign empty   = (count == '0);
   assign full    = (count == erx_cfg_pkg::QDEPTH);
   assign do_pop  = pop & !empty;
   assign do_push = push & (!full | do_pop);   // full drops the push

   assign head_pkt   = mem_pkt[rd_ptr];
   assign head_burst = mem_burst[rd_ptr];

   // storage
   always_ff @(posedge rx_lclk)
   begin
      if (do_push)
      begin
         mem_pkt[wr_ptr]   <= push_pkt;
         mem_burst[wr_ptr] <= push_burst;
      end
   end

   //##############################
   // pointers and count
   //##############################
   always_ff @(posedge rx_lclk or negedge erx_io_nreset)
   begin
      if (!erx_io_nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == erx_cfg_pkg::QDEPTH-1) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == erx_cfg_pkg::QDEPTH-1) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;      // none or both
         endcase
      end
   end

endmodule

// File: erx_tb_link.svh
//##############################
// link side driver for the receive testbench
// builds random packets and serializes frames into
// link words, included inside the testbench module
//##############################
`ifndef ERX_TB_LINK_SVH
`define ERX_TB_LINK_SVH

// random packet of one class, access always set
function automatic logic [erx_link_pkg::PW-1:0] make_pkt(input logic wr);
   logic [erx_link_pkg::PW-1:0] p;
   logic [31:0]                 r;
   erx_link_pkg::datamode_t     dm;
   r  = $random(seed);
   dm = erx_link_pkg::datamode_t'(r[1:0]);
   p  = '0;
   p[erx_link_pkg::ACC_BIT]         = 1'b1;
   p[erx_link_pkg::WR_BIT]          = wr;
   p[erx_link_pkg::DM_LSB +: 2]     = dm;
   p[erx_link_pkg::CM_LSB +: 4]     = r[5:2];
   p[erx_link_pkg::DST_LSB +: 32]   = $random(seed);
   p[erx_link_pkg::DATA_LSB +: 32]  = $random(seed);
   p[erx_link_pkg::SRC_LSB +: 32]   = $random(seed);
   return p;
endfunction

// one link word of a packet, wire order is byte swapped
function automatic logic [erx_link_pkg::LW-1:0] word_of(
   input logic [erx_link_pkg::PW-1:0] p,
   input int                          slot
);
   logic [31:0] dst;
   logic [31:0] data;
   logic [31:0] src;
   dst  = p[erx_link_pkg::DST_LSB +: 32];
   data = p[erx_link_pkg::DATA_LSB +: 32];
   src  = p[erx_link_pkg::SRC_LSB +: 32];
   case (slot)
      0:       word_of = {p[erx_link_pkg::CM_LSB +: 4], dst[31:28], 8'h00};
      1:       word_of = {dst[19:12], dst[27:20]};
      2:       word_of = {dst[3:0], p[erx_link_pkg::DM_LSB +: 2],
                          p[erx_link_pkg::WR_BIT], p[erx_link_pkg::ACC_BIT], dst[11:4]};
      3:       word_of = {data[23:16], data[31:24]};
      4:       word_of = {data[7:0], data[15:8]};
      5:       word_of = {src[23:16], src[31:24]};
      default: word_of = {src[7:0], src[15:8]};
   endcase
endfunction

// one frame, first packet in full, the rest as bursts
task automatic send_frame(input logic [erx_link_pkg::PW-1:0] pkts[$]);
   logic [erx_link_pkg::PW-1:0] exp_pkt;
   logic                        wr;
   int                          t;
   wr = pkts[0][erx_link_pkg::WR_BIT];   // whole frame has one class
   t  = 0;
   while ((wr ? link_wr_wait : link_rd_wait) && (t < WAIT_LIMIT))
   begin
      @(negedge rx_lclk);
      t++;
   end
   if (wr ? link_wr_wait : link_rd_wait)
   begin
      timeouts++;
      $display("timeout waiting for the link pushback to drop before a frame");
   end
   for (int i = 0; i < pkts.size(); i++)
   begin
      // burst keeps header and dstaddr of the first packet
      exp_pkt = (i == 0) ? pkts[0] : {pkts[i][erx_link_pkg::PW-1:erx_link_pkg::DATA_LSB],
                                      pkts[0][erx_link_pkg::DATA_LSB-1:0]};
      if (wr)
         exp_wr.push_back({(i != 0), exp_pkt});
      else
         exp_rd.push_back({(i != 0), exp_pkt});
      for (int s = (i == 0) ? 0 : erx_link_pkg::BURST_SLOT; s < erx_link_pkg::NSLOT; s++)
      begin
         @(negedge rx_lclk);
         link_frame = 1'b1;
         link_word  = word_of(pkts[i], s);
      end
   end
   @(negedge rx_lclk);
   link_frame = 1'b0;
   link_word  = '0;
   repeat (4) @(negedge rx_lclk);   // last packet reaches its queue
endtask

`endif

// File: tb_erx_core.sv
`timescale 1ns/10ps
//##############################
// testbench for the receive link core
// directed tests send frames on the link words, a
// monitor checks every packet taken by the consumer
//##############################
module tb_erx_core;

   localparam int WAIT_LIMIT  = 200;    // cycles per wait loop
   localparam int DRAIN_LIMIT = 2000;

   logic                          rx_lclk;
   logic                          erx_io_nreset;
   logic                          link_frame;
   logic [erx_link_pkg::LW-1:0]   link_word;
   logic                          rx_wait;
   logic                          link_wr_wait;
   logic                          link_rd_wait;
   logic                          rx_access;
   logic                          rx_burst;
   logic [erx_link_pkg::PW-1:0]   rx_packet;

   logic [erx_link_pkg::PW:0]     exp_wr[$];   // burst flag on top
   logic [erx_link_pkg::PW:0]     exp_rd[$];
   logic [erx_link_pkg::PW:0]     mon_exp;
   int                            seed     = 62480;
   int                            errors   = 0;
   int                            timeouts = 0;
   int                            received = 0;

   erx_core dut (
      .rx_lclk       (rx_lclk),
      .erx_io_nreset (erx_io_nreset),
      .link_frame    (link_frame),
      .link_word     (link_word),
      .rx_wait       (rx_wait),
      .link_wr_wait  (link_wr_wait),
      .link_rd_wait  (link_rd_wait),
      .rx_access     (rx_access),
      .rx_burst      (rx_burst),
      .rx_packet     (rx_packet)
   );

   always #4 rx_lclk = ~rx_lclk;   // 8 ns period

   `include "erx_tb_link.svh"

   //##############################
   // compare tasks
   //##############################
   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %s got 0x%0h exp 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_mode(input string name, input erx_link_pkg::datamode_t got,
                             input erx_link_pkg::datamode_t exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %s got 0x%0h exp 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_packet(input string name, input logic [erx_link_pkg::PW-1:0] got,
                               input logic [erx_link_pkg::PW-1:0] exp);
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %s got 0x%h exp 0x%h", name, got, exp);
      end
      check_flag({name, ".access"}, got[erx_link_pkg::ACC_BIT], exp[erx_link_pkg::ACC_BIT]);
      check_flag({name, ".write"}, got[erx_link_pkg::WR_BIT], exp[erx_link_pkg::WR_BIT]);
      check_mode({name, ".datamode"}, erx_link_pkg::datamode_t'(got[erx_link_pkg::DM_LSB +: 2]),
                 erx_link_pkg::datamode_t'(exp[erx_link_pkg::DM_LSB +: 2]));
   endtask

   //##############################
   // monitor and scoreboard
   //##############################
   always @(posedge rx_lclk)
   begin
      if (erx_io_nreset && rx_access && !rx_wait)   // transfer this edge
      begin
         received++;
         if (rx_packet[erx_link_pkg::WR_BIT] && (exp_wr.size() > 0))
            mon_exp = exp_wr.pop_front();
         else if (!rx_packet[erx_link_pkg::WR_BIT] && (exp_rd.size() > 0))
            mon_exp = exp_rd.pop_front();
         else
            mon_exp = 'x;
         if ($isunknown(mon_exp))
         begin
            errors++;
            $display("packet 0x%h arrived with none expected for its class", rx_packet);
         end
         else
         begin
            check_packet("rx_packet", rx_packet, mon_exp[erx_link_pkg::PW-1:0]);
            check_flag("rx_burst", rx_burst, mon_exp[erx_link_pkg::PW]);
         end
      end
   end

   // every expected packet taken, or give up
   task automatic drain_expected;
      int t;
      t = 0;
      while (((exp_wr.size() + exp_rd.size()) != 0) && (t < DRAIN_LIMIT))
      begin
         @(negedge rx_lclk);
         t++;
      end
      if ((exp_wr.size() + exp_rd.size()) != 0)
      begin
         timeouts++;
         $display("timeout, %0d packets never reached the consumer",
                  exp_wr.size() + exp_rd.size());
      end
   endtask

   //##############################
   // directed tests
   //##############################
   task automatic reset_and_single;
      logic [erx_link_pkg::PW-1:0] frame[$];
      check_flag("rx_access", rx_access, 1'b0);
      check_flag("link_wr_wait", link_wr_wait, 1'b0);
      check_flag("link_rd_wait", link_rd_wait, 1'b0);
      frame.push_back(make_pkt(1'b1));
      send_frame(frame);
      drain_expected();
   endtask

   task automatic read_then_write;
      logic [erx_link_pkg::PW-1:0] frame[$];
      frame.push_back(make_pkt(1'b0));
      send_frame(frame);
      frame.delete();
      frame.push_back(make_pkt(1'b1));
      send_frame(frame);
      drain_expected();
   endtask

   task automatic burst_frame;
      logic [erx_link_pkg::PW-1:0] frame[$];
      frame.push_back(make_pkt(1'b0));
      frame.push_back(make_pkt(1'b1));   // header not resent, stays a read
      frame.push_back(make_pkt(1'b1));
      send_frame(frame);
      drain_expected();
   endtask

   // one write sits in the output stage, the rest fill the queue
   task automatic write_backpressure;
      logic [erx_link_pkg::PW-1:0] frame[$];
      @(negedge rx_lclk);
      rx_wait = 1'b1;
      for (int n = 0; n <= erx_cfg_pkg::WAIT_LEVEL + 1; n++)
      begin
         check_flag("link_wr_wait", link_wr_wait, (n > erx_cfg_pkg::WAIT_LEVEL));
         check_flag("link_rd_wait", link_rd_wait, 1'b0);
         if (n <= erx_cfg_pkg::WAIT_LEVEL)
         begin
            frame.delete();
            frame.push_back(make_pkt(1'b1));
            send_frame(frame);
         end
      end
      rx_wait = 1'b0;
      drain_expected();
      check_flag("link_wr_wait", link_wr_wait, 1'b0);
   endtask

   task automatic random_mix;
      logic [erx_link_pkg::PW-1:0] frame[$];
      logic [31:0]                 r;
      int                          len;
      int                          sent;
      sent = 0;
      while (sent < 40)
      begin
         r   = $random(seed);
         len = 1 + (int'(r[5:4]) % 3);      // one to three packets
         if (len > 40 - sent)
            len = 40 - sent;
         frame.delete();
         for (int i = 0; i < len; i++)
            frame.push_back(make_pkt(r[0]));
         send_frame(frame);
         sent += len;
      end
      drain_expected();
   endtask

   initial
   begin
      rx_lclk       = 1'b0;
      erx_io_nreset = 1'b0;
      link_frame    = 1'b0;
      link_word     = '0;
      rx_wait       = 1'b0;
      repeat (8) @(negedge rx_lclk);
      erx_io_nreset = 1'b1;
      reset_and_single();
      read_then_write();
      burst_frame();
      write_backpressure();
      random_mix();
      repeat (10) @(negedge rx_lclk);   // catch late duplicates
      $display("errors %0d  timeouts %0d  packets %0d", errors, timeouts, received);
      if ((errors == 0) && (timeouts == 0))
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule
